/* filelist.f */
logic/jsonUartPkg.sv
logic/driveCommandReg.sv
logic/jsonMessageRom.sv
logic/frameSequencer.sv
logic/uartTx.sv
logic/jsonUartTop.sv
tb/jsonUartAssert.sv
tb/jsonUartTb.sv

/* logic/driveCommandReg.sv */
`timescale 1ns/1ps

module driveCommandReg import jsonUartPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic [2:0] stateControl,        // Raw switches, asynchronous
    input  logic      cmdLoad,              // Frame start strobe from sequencer
    output driveCmd_e cmd                   // Command for the current frame
);

    logic [2:0] syncMeta;                   // First synchroniser stage
    logic [2:0] syncOut;                    // Second stage, safe to use
    driveCmd_e  mappedCmd;                  // Decoded switch value

    // Two-flop synchroniser on the switch bus
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            syncMeta <= 3'd0;
            syncOut  <= 3'd0;
        end else begin
            syncMeta <= stateControl;
            syncOut  <= syncMeta;
        end
    end

    // Unlisted codes fall back to stop
    always_comb begin
        case (syncOut)
            3'd1:    mappedCmd = cmdSpinLeft;
            3'd2:    mappedCmd = cmdSpinRight;
            3'd3:    mappedCmd = cmdCruise;
            3'd5:    mappedCmd = cmdSprint;
            default: mappedCmd = cmdStop;   // 0, 4, 6, 7
        endcase
    end

    // Only updates between frames, so a frame never mixes commands
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd <= cmdStop;
        end else if (cmdLoad) begin
            cmd <= mappedCmd;
        end
    end

endmodule

/* logic/frameSequencer.sv */
`timescale 1ns/1ps

module frameSequencer import jsonUartPkg::*; #(
    parameter int gapCycles = 0                 // Idle cycles between frames
) (
    input  logic               clk,
    input  logic               rst,
    input  driveCmd_e          cmd,             // Command of the current frame
    input  logic [7:0]         msgByte,         // ROM byte at byteIdx
    input  logic [msgIdxW:0]   msgLen,          // ROM frame length
    input  logic               txReady,         // UART can take a byte
    output logic               cmdLoad,         // Latch strobe to command reg
    output logic [msgIdxW-1:0] byteIdx,         // ROM address
    output logic [7:0]         txData,          // Byte offered to UART
    output logic               txValid,         // Offer strobe, held to accept
    output logic               done,            // One cycle at frame end
    output ledStatus_t         status           // LED word
);

    localparam int gapW = (gapCycles > 0) ? $clog2(gapCycles + 1) : 1;

    seqState_e        state;
    logic [gapW-1:0]  gapCnt;                   // Gap timer
    logic [7:0]       lastByte;                 // Last accepted byte
    logic             lastIdx;                  // Offering the final byte

    assign lastIdx = ({1'b0, byteIdx} == (msgLen - {{msgIdxW{1'b0}}, 1'b1}));

    // Strobes decoded straight from the state
    assign cmdLoad = (state == seqLoad);
    assign done    = (state == seqDone);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= seqGap;
            gapCnt   <= '0;
            byteIdx  <= '0;
            txValid  <= 1'b0;
            lastByte <= 8'h00;
        end else begin
            case (state)
                seqGap: begin
                    if (gapCnt == gapW'(gapCycles)) begin
                        gapCnt <= '0;
                        state  <= seqLoad;
                    end else begin
                        gapCnt <= gapCnt + 1'b1;
                    end
                end
                seqLoad: begin
                    byteIdx <= '0;              // cmd valid from next cycle
                    state   <= seqSend;
                end
                seqSend: begin
                    if (!txValid) begin
                        txValid <= 1'b1;        // Byte captured below
                    end else if (txReady) begin // Accept
                        txValid  <= 1'b0;
                        lastByte <= txData;
                        if (lastIdx) begin
                            state <= seqDrain;
                        end else begin
                            byteIdx <= byteIdx + 1'b1;
                        end
                    end
                end
                seqDrain: begin
                    if (txReady) state <= seqDone;  // Stop bit of newline sent
                end
                seqDone: state <= seqGap;
                default: state <= seqGap;
            endcase
        end
    end

    // Offered byte, stable while txValid is high
    always_ff @(posedge clk) begin
        if (state == seqSend && !txValid) begin
            txData <= msgByte;
        end
    end

    always_comb begin
        status.busy     = (state == seqLoad) || (state == seqSend) || (state == seqDrain);
        status.spare    = '0;
        status.cmd      = cmd;
        status.lastByte = lastByte;
    end

endmodule

/* logic/jsonMessageRom.sv */
`timescale 1ns/1ps

module jsonMessageRom import jsonUartPkg::*; (
    input  driveCmd_e            cmd,       // Latched drive command
    input  logic [msgIdxW-1:0]   byteIdx,   // Byte position in the frame
    output logic [7:0]           msgByte,   // ASCII byte at byteIdx
    output logic [msgIdxW:0]     msgLen     // Frame length incl. newline
);

    localparam int lastPos = maxMsgLen - 1;     // Index of the final slot
    localparam logic [7:0] newLine = 8'h0A;

    // Messages left aligned, first char in the top byte
    // Unused tail slots hold newlines so an overrun reads '\n'
    localparam logic [8*maxMsgLen-1:0] spinLeftMsg = {
        "{\"T\":1,\"L\":-0.25,\"R\":0.25}",     // 26 chars, minus is 0x2D
        newLine                                  // 27 total
    };

    localparam logic [8*maxMsgLen-1:0] spinRightMsg = {
        "{\"T\":1,\"L\":0.25,\"R\":-0.25}",     // Mirror of spin left
        newLine
    };

    localparam logic [8*maxMsgLen-1:0] cruiseMsg = {
        "{\"T\":1,\"L\":0.25,\"R\":0.25}",      // 25 chars
        newLine,
        newLine                                  // Pad slot
    };

    localparam logic [8*maxMsgLen-1:0] sprintMsg = {
        "{\"T\":1,\"L\":0.5,\"R\":0.5}",        // 23 chars
        newLine,
        {3{newLine}}                             // Pad slots
    };

    localparam logic [8*maxMsgLen-1:0] stopMsg = {
        "{\"T\":1,\"L\":0,\"R\":0}",            // 19 chars
        newLine,
        {7{newLine}}                             // Pad slots
    };

    logic [8*maxMsgLen-1:0] msgVec;             // Selected message image

    // Pick the message and its length
    always_comb begin
        case (cmd)
            cmdSpinLeft: begin
                msgVec = spinLeftMsg;
                msgLen = (msgIdxW+1)'(27);
            end
            cmdSpinRight: begin
                msgVec = spinRightMsg;
                msgLen = (msgIdxW+1)'(27);
            end
            cmdCruise: begin
                msgVec = cruiseMsg;
                msgLen = (msgIdxW+1)'(26);
            end
            cmdSprint: begin
                msgVec = sprintMsg;
                msgLen = (msgIdxW+1)'(24);
            end
            default: begin
                msgVec = stopMsg;                // Stop and anything unknown
                msgLen = (msgIdxW+1)'(20);
            end
        endcase
    end

    // Byte lookup, index 0 is the opening brace
    always_comb begin
        if (int'(byteIdx) <= lastPos) begin
            msgByte = msgVec[8*(lastPos - int'(byteIdx)) +: 8];
        end else begin
            msgByte = newLine;                   // Index 27..31
        end
    end

endmodule

/* logic/jsonUartPkg.sv */
package jsonUartPkg;

    localparam int maxMsgLen = 27;          // Longest frame, spin commands
    localparam int msgIdxW   = 5;           // Byte index width, covers 0..31

    // Drive commands, values match the switch codes
    typedef enum logic [2:0] {
        cmdStop      = 3'd0,                // L 0, R 0
        cmdSpinLeft  = 3'd1,                // L -0.25, R 0.25
        cmdSpinRight = 3'd2,                // L 0.25, R -0.25
        cmdCruise    = 3'd3,                // L 0.25, R 0.25
        cmdSprint    = 3'd5                 // L 0.5, R 0.5
    } driveCmd_e;

    typedef enum logic [2:0] {
        seqGap,                             // Idle gap between frames
        seqLoad,                            // Latch command for the frame
        seqSend,                            // Offer message bytes
        seqDrain,                           // Wait out the last byte
        seqDone                             // Frame end strobe
    } seqState_e;

    typedef enum logic [1:0] {
        parNone,                            // 8N1
        parOdd,
        parEven
    } parity_e;

    // LED status word, busy on the top LED
    typedef struct packed {
        logic       busy;                   // Frame in progress
        logic [5:0] spare;                  // Tied low
        driveCmd_e  cmd;                    // Latched command
        logic [7:0] lastByte;               // Last byte taken by the UART
    } ledStatus_t;

endpackage

/* logic/jsonUartTop.sv */
`timescale 1ns/1ps

module jsonUartTop import jsonUartPkg::*; #(
    parameter int      clksPerBit = 434,        // Bit period in clocks
    parameter int      gapCycles  = 0,          // Idle cycles between frames
    parameter parity_e parityMode = parNone     // 8N1 by default
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [2:0] stateControl,            // Drive command switches
    output logic       txLine,                  // UART out to the robot
    output ledStatus_t ledr,                    // Status LEDs
    output logic       done                     // Frame complete strobe
);

    driveCmd_e          cmd;                    // Latched command
    logic               cmdLoad;
    logic [msgIdxW-1:0] byteIdx;
    logic [7:0]         msgByte;
    logic [msgIdxW:0]   msgLen;
    logic [7:0]         txData;
    logic               txValid;
    logic               txReady;

    driveCommandReg driveCommandReg_i (
        .clk          (clk),
        .rst          (rst),
        .stateControl (stateControl),
        .cmdLoad      (cmdLoad),
        .cmd          (cmd)
    );

    jsonMessageRom jsonMessageRom_i (
        .cmd     (cmd),
        .byteIdx (byteIdx),
        .msgByte (msgByte),
        .msgLen  (msgLen)
    );

    frameSequencer #(
        .gapCycles (gapCycles)
    ) frameSequencer_i (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .msgByte (msgByte),
        .msgLen  (msgLen),
        .txReady (txReady),
        .cmdLoad (cmdLoad),
        .byteIdx (byteIdx),
        .txData  (txData),
        .txValid (txValid),
        .done    (done),
        .status  (ledr)
    );

    uartTx #(
        .clksPerBit (clksPerBit),
        .parityMode (parityMode)
    ) uartTx_i (
        .clk     (clk),
        .rst     (rst),
        .txData  (txData),
        .txValid (txValid),
        .txReady (txReady),
        .txLine  (txLine)
    );

endmodule

/* logic/uartTx.sv */
`timescale 1ns/1ps

module uartTx import jsonUartPkg::*; #(
    parameter int      clksPerBit = 434,        // 115200 baud at 50 MHz
    parameter parity_e parityMode = parNone
) (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] txData,                  // Byte to send
    input  logic       txValid,                 // Byte offered
    output logic       txReady,                 // Idle, can accept
    output logic       txLine                   // Serial out, idles high
);

    localparam int perW      = (clksPerBit > 1) ? $clog2(clksPerBit) : 1;
    localparam int frameBits = (parityMode == parNone) ? 10 : 11;
    localparam int lastBit   = frameBits - 1;   // Stop bit position

    logic            busy;                      // Frame on the line
    logic [perW-1:0] periodCnt;                 // Cycles within a bit
    logic [3:0]      bitCnt;                    // 0 start, 1..8 data, then parity/stop
    logic [7:0]      shReg;                     // Data bits, LSB out first
    logic            parBit;                    // Parity of the latched byte
    logic [3:0]      nextBit;                   // Position entered next

    assign txReady = !busy;
    assign nextBit = bitCnt + 4'd1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            periodCnt <= '0;
            bitCnt    <= 4'd0;
            txLine    <= 1'b1;
        end else if (!busy) begin
            txLine <= 1'b1;
            if (txValid) begin                  // Accept, start bit next cycle
                busy      <= 1'b1;
                periodCnt <= '0;
                bitCnt    <= 4'd0;
                txLine    <= 1'b0;
            end
        end else if (periodCnt == perW'(clksPerBit - 1)) begin
            periodCnt <= '0;
            bitCnt    <= nextBit;
            if (bitCnt == 4'(lastBit)) begin
                busy   <= 1'b0;                 // Ready again next cycle
                txLine <= 1'b1;
            end else if (nextBit <= 4'd8) begin
                txLine <= shReg[0];             // Data bit
            end else if (nextBit == 4'd9 && parityMode != parNone) begin
                txLine <= parBit;
            end else begin
                txLine <= 1'b1;                 // Stop bit
            end
        end else begin
            periodCnt <= periodCnt + 1'b1;
        end
    end

    // Payload path
    always_ff @(posedge clk) begin
        if (!busy && txValid) begin
            shReg  <= txData;
            parBit <= (parityMode == parOdd) ? ~^txData : ^txData;
        end else if (busy && periodCnt == perW'(clksPerBit - 1)
                     && nextBit <= 4'd8) begin
            shReg <= shReg >> 1;                // Next data bit to LSB
        end
    end

endmodule

/* tb/jsonUartAssert.sv */
`timescale 1ns/1ps

module jsonUartAssert #(
    parameter bit uartSide = 1'b0               // Set on the UART instance
) (
    input logic       clk,
    input logic       rst,
    input logic [7:0] txData,                   // Byte on offer
    input logic       txValid,
    input logic       txReady,
    input logic       done,                     // Used on the sequencer side
    input logic       txLine                    // Used on the UART side
);

    // Offer held and frozen until the UART takes it
    property holdOffer;
        @(posedge clk) disable iff (rst)
            (txValid && !txReady) |=> (txValid && $stable(txData));
    endproperty

    property doneOneCycle;
        @(posedge clk) disable iff (rst) done |=> !done;
    endproperty

    property idleLineHigh;
        @(posedge clk) disable iff (rst) txReady |-> txLine;
    endproperty

    if (uartSide) begin : lineChecks
        assert property (idleLineHigh) else $error("txLine low while UART idle");
    end else begin : offerChecks
        assert property (holdOffer)    else $error("txData or txValid moved before accept");
        assert property (doneOneCycle) else $error("done held longer than one cycle");
    end

endmodule

// Sequencer side sees the strobe, UART side sees the line
bind frameSequencer jsonUartAssert #(.uartSide(1'b0)) seqChk (
    .clk     (clk),
    .rst     (rst),
    .txData  (txData),
    .txValid (txValid),
    .txReady (txReady),
    .done    (done),
    .txLine  (1'b1)
);

bind uartTx jsonUartAssert #(.uartSide(1'b1)) txChk (
    .clk     (clk),
    .rst     (rst),
    .txData  (txData),
    .txValid (txValid),
    .txReady (txReady),
    .done    (1'b0),
    .txLine  (txLine)
);

/* tb/jsonUartTb.sv */
`timescale 1ns/1ps

module jsonUartTb import jsonUartPkg::*; ();

    localparam int clksPerBit = 8;
    localparam int gapCycles  = 16;
    localparam int clkNs      = 4;
    localparam int bitNs      = clksPerBit * clkNs;          // 32 ns per bit
    localparam int frameNs    = maxMsgLen * 10 * bitNs;       // Longest frame
    localparam int gapNs      = (gapCycles + 4) * clkNs;      // Gap, load, drain, done
    localparam int runFrames  = 28;                           // Upper bound over all tests
    localparam int watchdogNs = runFrames * (frameNs + gapNs) * 2;

    logic       clk;
    logic       rst;
    logic [2:0] stateControl;
    logic       txLine;
    ledStatus_t ledr;
    logic       done;

    integer     seed = 53772;                   // Fixed seed for test 4
    int         errCount;
    int         checkCount;
    int         testErrStart;                   // errCount when a test began
    int         doneCount;                      // done pulses seen so far
    logic [7:0] rxBytes[$];                     // Last decoded frame
    bit         rxStopOk;                       // All stop bits in frame good

    jsonUartTop #(
        .clksPerBit (clksPerBit),
        .gapCycles  (gapCycles)
    ) jsonUartTop_i (
        .clk          (clk),
        .rst          (rst),
        .stateControl (stateControl),
        .txLine       (txLine),
        .ledr         (ledr),
        .done         (done)
    );

    always #2 clk = ~clk;                       // 4 ns period

    always @(negedge clk) begin
        if (done) doneCount++;
    end

    task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] act);
        checkCount++;
        if (exp !== act) begin
            errCount++;
            $display("error %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    // JSON line for a switch code, speeds from the command table
    function automatic string expectMsg(input int code);
        string l;
        string r;
        case (code)
            1:       begin l = "-0.25"; r = "0.25";  end
            2:       begin l = "0.25";  r = "-0.25"; end
            3:       begin l = "0.25";  r = "0.25";  end
            5:       begin l = "0.5";   r = "0.5";   end
            default: begin l = "0";     r = "0";     end  // 0, 4, 6, 7
        endcase
        return $sformatf("{\"T\":1,\"L\":%s,\"R\":%s}\n", l, r);
    endfunction

    function automatic bit sameAs(input string s);
        if (rxBytes.size() != s.len()) return 0;
        for (int i = 0; i < s.len(); i++) begin
            if (rxBytes[i] !== s[i]) return 0;
        end
        return 1;
    endfunction

    function automatic bit isLegal();
        return sameAs(expectMsg(0)) || sameAs(expectMsg(1)) || sameAs(expectMsg(2))
            || sameAs(expectMsg(3)) || sameAs(expectMsg(5));
    endfunction

    task automatic driveCode(input logic [2:0] c);
        @(posedge clk);
        #1 stateControl = c;
    endtask

    task automatic waitDone();
        do @(negedge clk); while (!done);
    endtask

    // Start bit edge, then mid-bit samples
    task automatic recvByte(output logic [7:0] data, output bit stopOk);
        @(negedge txLine);
        #(bitNs / 2);
        if (txLine !== 1'b0) begin
            errCount++;
            $display("Start bit on the serial line was only a glitch");
        end
        for (int i = 0; i < 8; i++) begin
            #(bitNs);
            data[i] = txLine;                   // LSB first
        end
        #(bitNs);
        stopOk = (txLine === 1'b1);
    endtask

    task automatic recvFrame();
        logic [7:0] b;
        bit         ok;
        rxBytes.delete();
        rxStopOk = 1'b1;
        do begin
            recvByte(b, ok);
            rxBytes.push_back(b);
            if (!ok) rxStopOk = 1'b0;
        end while (b !== 8'h0A && rxBytes.size() < maxMsgLen);
    endtask

    task automatic checkFrame(input string name, input int code);
        string s;
        int    n;
        s = expectMsg(code);
        n = (s.len() < rxBytes.size()) ? s.len() : rxBytes.size();
        checkVal({name, " length"}, s.len(), rxBytes.size());
        for (int i = 0; i < n; i++) begin
            checkVal($sformatf("%s byte %0d", name, i), s[i], rxBytes[i]);
        end
        if (!rxStopOk) begin
            errCount++;
            $display("Missing stop bit in frame of %s", name);
        end
    endtask

    task automatic finishTest(input string name);
        $display("Test %s finished with %0d errors", name, errCount - testErrStart);
    endtask

    task automatic resetIdleTest();
        testErrStart = errCount;
        repeat (4) begin
            @(negedge clk);
            checkVal("resetIdle txLine", 1, txLine);
            checkVal("resetIdle done", 0, done);
            checkVal("resetIdle busy", 0, ledr.busy);
        end
        @(posedge clk);
        #1 rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            checkVal("resetIdle txLine after", 1, txLine);
            checkVal("resetIdle done after", 0, done);
            checkVal("resetIdle busy after", 0, ledr.busy);
            checkVal("resetIdle lastByte", 0, ledr.lastByte);
        end
        finishTest("resetIdle");
    endtask

    task automatic stopFrameTest();
        testErrStart = errCount;
        recvFrame();                            // First frame after reset
        checkFrame("stopFrame", 0);
        finishTest("stopFrame");
    endtask

    task automatic eachCommandTest();
        int codeList[5];
        testErrStart = errCount;
        codeList = '{1, 2, 3, 5, 6};            // 6 is unlisted, sent as stop
        foreach (codeList[k]) begin
            driveCode(codeList[k][2:0]);
            waitDone();                         // Frame in flight ends
            recvFrame();
            checkFrame($sformatf("eachCommand code %0d", codeList[k]), codeList[k]);
        end
        finishTest("eachCommand");
    endtask

    task automatic coherentFrameTest();
        int legalCodes[6];
        int pick;
        int delay;
        testErrStart = errCount;
        legalCodes = '{0, 1, 2, 3, 5, 6};
        for (int round = 0; round < 3; round++) begin
            pick  = legalCodes[$unsigned($random(seed)) % 6];
            delay = $unsigned($random(seed)) % 2048;      // Often lands mid-frame
            fork
                begin
                    repeat (delay) @(posedge clk);
                    #1 stateControl = pick[2:0];
                end
                begin
                    waitDone();
                    recvFrame();
                    if (!isLegal() || !rxStopOk) begin
                        errCount++;
                        $display("Frame in round %0d matches no legal message", round);
                    end
                end
            join
            waitDone();
            recvFrame();
            checkFrame($sformatf("coherent round %0d", round), pick);
        end
        finishTest("coherentFrame");
    endtask

    task automatic repeatDoneTest();
        int startCnt;
        int waitCyc;
        testErrStart = errCount;
        driveCode(3'd3);
        waitDone();                             // Next frame carries cruise
        for (int f = 0; f < 3; f++) begin
            @(posedge clk);
            startCnt = doneCount;
            recvFrame();
            checkFrame($sformatf("repeatDone frame %0d", f), 3);
            checkVal("repeatDone early done", startCnt, doneCount);
            waitCyc = 0;
            while (doneCount == startCnt && waitCyc < 20) begin
                @(posedge clk);
                waitCyc++;
            end
            repeat (2) @(posedge clk);
            checkVal("repeatDone done count", startCnt + 1, doneCount);
            @(negedge clk);
            checkVal("repeatDone lastByte", 8'h0A, ledr.lastByte);
            checkVal("repeatDone cmd", 3, ledr.cmd);
            checkVal("repeatDone spare", 0, ledr.spare);
        end
        finishTest("repeatDone");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        stateControl = 3'd0;
        errCount     = 0;
        checkCount   = 0;
        testErrStart = 0;
        doneCount    = 0;
        resetIdleTest();
        stopFrameTest();
        eachCommandTest();
        coherentFrameTest();
        repeatDoneTest();
        $display("Summary: %0d checks, %0d errors", checkCount, errCount);
        if (errCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Bounded by frame count times worst frame and gap, doubled
    initial begin
        #(watchdogNs);
        $display("Watchdog expired, frames stopped arriving on the serial line");
        $display("Testbench failed");
        $finish;
    end

endmodule
